// File: logic/keyDecoder.sv
/* Stage 1. Registers the held key byte as a command, one clock later.
   Unknown codes give cmdNone. */
`include "pet_config.svh"

module keyDecoder (
    input  logic          Reset,
    input  logic          frame_clk,
    input  logic [7:0]    key,
    output petPkg::petCmd cmd
);
    import petPkg::*;

    petCmd keyCmd;

    // Scan code lookup
    always_comb begin
        if (key == `PET_KEY_FEED) begin
            keyCmd = cmdFeed;
        end else if (key == `PET_KEY_PET) begin
            keyCmd = cmdPet;
        end else if (key == `PET_KEY_START) begin
            keyCmd = cmdStart;
        end else begin
            keyCmd = cmdNone;
        end
    end

    // Register keeps the keyboard byte off the FSM paths
    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            cmd <= cmdNone;
        end else begin
            cmd <= keyCmd;
        end
    end

endmodule

// File: logic/petController.sv
/* Stage 2. Steps the pet FSM once every PET_FRAME_DIV clocks; view and
   counters only change on a step. Counters saturate at 0 and PET_STAT_MAX. */
`include "pet_config.svh"

module petController (
    input  logic            Reset,
    input  logic            frame_clk,
    input  petPkg::petCmd   cmd,
    output petPkg::petView  view,
    output petPkg::petStats stats
);
    import petPkg::*;

    localparam int DivW = (`PET_FRAME_DIV > 1) ? $clog2(`PET_FRAME_DIV) : 1;

    logic [DivW-1:0] divCnt;
    logic            step;

    petView  curView;
    petView  nxtView;
    petStats curStats;
    petStats nxtStats;

    logic allHappy;
    logic anyZero;
    logic lastFrame;

    // ----------------------------------------
    // Counter helpers
    // ----------------------------------------
    function automatic statVal decSat(input statVal v);
        return (v == '0) ? v : v - 1'b1;   // Floor at 0
    endfunction

    function automatic statVal incCap(input statVal v);
        return (v < statVal'(`PET_STAT_MAX)) ? v + 1'b1 : v;
    endfunction

    // ----------------------------------------
    // Frame pacing
    // ----------------------------------------
    assign step = (divCnt == DivW'(`PET_FRAME_DIV - 1));

    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            divCnt <= '0;
        end else if (step) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Mood tests used by phCheck
    assign allHappy = (curStats.health    >= statVal'(`PET_HAPPY_MIN)) &&
                      (curStats.fullness  >= statVal'(`PET_HAPPY_MIN)) &&
                      (curStats.affection >= statVal'(`PET_HAPPY_MIN));
    assign anyZero  = (curStats.health == '0) || (curStats.fullness == '0) ||
                      (curStats.affection == '0);
    assign lastFrame = (curView.frame == 3'd7);

    // ----------------------------------------
    // Step rules
    // ----------------------------------------
    always_comb begin
        nxtView  = curView;
        nxtStats = curStats;
        unique case (curView.phase)
            phStart: begin
                nxtView.phase      = phCheck;
                nxtView.frame      = '0;
                nxtStats.health    = statVal'(`PET_STAT_INIT);
                nxtStats.fullness  = statVal'(`PET_STAT_INIT);
                nxtStats.affection = statVal'(`PET_STAT_INIT);
            end
            phCheck: begin
                nxtView.frame = '0;
                if (allHappy) begin
                    nxtView.phase = phIdleHappy;
                end else if (anyZero) begin
                    nxtView.phase = phDead;
                end else begin
                    nxtView.phase = phIdleSad;
                end
            end
            phIdleHappy, phIdleSad: begin
                if (cmd == cmdFeed) begin
                    nxtView.phase = phFeedGate;
                    nxtView.frame = '0;
                end else if (cmd == cmdPet) begin
                    nxtView.phase = phPetGate;
                    nxtView.frame = '0;
                end else if (lastFrame) begin
                    nxtView.phase      = phCheck;     // One day gone by
                    nxtView.frame      = '0;
                    nxtStats.health    = decSat(curStats.health);
                    nxtStats.fullness  = decSat(curStats.fullness);
                    nxtStats.affection = decSat(curStats.affection);
                end else begin
                    nxtView.frame = curView.frame + 1'b1;
                end
            end
            phFeedGate: begin
                nxtView.frame = '0;
                if (curStats.fullness < statVal'(`PET_STAT_MAX)) begin
                    nxtView.phase = phFeed;
                end else begin
                    nxtView.phase = phUpset;               // Already full
                end
            end
            phFeed: begin
                if (lastFrame) begin
                    nxtView.phase      = phCheck;
                    nxtView.frame      = '0;
                    nxtStats.health    = incCap(curStats.health);
                    nxtStats.fullness  = incCap(curStats.fullness);
                    nxtStats.affection = decSat(curStats.affection);
                end else begin
                    nxtView.frame = curView.frame + 1'b1;
                end
            end
            phPetGate: begin
                nxtView.frame = '0;
                if (curStats.affection < statVal'(`PET_STAT_MAX)) begin
                    nxtView.phase = phPet;
                end else begin
                    nxtView.phase = phUpset;               // Had enough petting
                end
            end
            phPet: begin
                if (lastFrame) begin
                    nxtView.phase      = phCheck;
                    nxtView.frame      = '0;
                    nxtStats.health    = incCap(curStats.health);
                    nxtStats.affection = incCap(curStats.affection);
                    nxtStats.fullness  = decSat(curStats.fullness);
                end else begin
                    nxtView.frame = curView.frame + 1'b1;
                end
            end
            phUpset: begin
                nxtView.phase   = phCheck;
                nxtView.frame   = '0;
                nxtStats.health = decSat(curStats.health);
            end
            phDead: begin
                nxtView.frame = '0;
                if (cmd == cmdStart) begin
                    nxtView.phase = phStart;   // Feed and pet are ignored
                end
            end
            default: begin
                nxtView.phase = phStart;       // Unused encodings recover
                nxtView.frame = '0;
            end
        endcase
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            curView.phase      <= phStart;
            curView.frame      <= '0;
            curStats.health    <= statVal'(`PET_STAT_INIT);
            curStats.fullness  <= statVal'(`PET_STAT_INIT);
            curStats.affection <= statVal'(`PET_STAT_INIT);
        end else if (step) begin
            curView  <= nxtView;
            curStats <= nxtStats;
        end
    end

    assign view  = curView;
    assign stats = curStats;

endmodule

// File: logic/petPkg.sv
/* Shared types for the pet core. Widths come from pet_config.svh. */
package petPkg;

    `include "pet_config.svh"

    // Command decoded from the held key
    typedef enum logic [1:0] {
        cmdNone  = 2'd0,
        cmdFeed  = 2'd1,
        cmdPet   = 2'd2,
        cmdStart = 2'd3
    } petCmd;

    // ----------------------------------------
    // Behavior phases
    // ----------------------------------------
    typedef enum logic [3:0] {
        phStart     = 4'd0,
        phCheck     = 4'd1,
        phIdleHappy = 4'd2,
        phIdleSad   = 4'd3,
        phFeedGate  = 4'd4,     // Decides feed or upset
        phFeed      = 4'd5,
        phPetGate   = 4'd6,     // Decides pet or upset
        phPet       = 4'd7,
        phUpset     = 4'd8,
        phDead      = 4'd9
    } petPhase;

    // One well-being counter
    typedef logic [`PET_STAT_W-1:0] statVal;

    typedef struct packed {
        statVal health;
        statVal fullness;
        statVal affection;
    } petStats;

    // What the display needs to pick a sprite
    typedef struct packed {
        petPhase    phase;
        logic [2:0] frame;      // 0..7 for steps 1..8
    } petView;

endpackage

// File: logic/petTop.sv
/* Pet core top. Key is a held level; Sprite and stats are registered levels.
   A key needs at least 2 clocks before the step that uses it. */
module petTop (
    input  logic            Reset,
    input  logic            frame_clk,
    input  logic [7:0]      key,
    output logic [7:0]      Sprite,
    output petPkg::petStats stats
);
    import petPkg::*;

    petCmd  cmdW;    // Decoder to FSM
    petView viewW;   // FSM to sprite encoder

    keyDecoder keyDec0 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .key       (key),
        .cmd       (cmdW)
    );

    petController ctrl0 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .cmd       (cmdW),
        .view      (viewW),
        .stats     (stats)
    );

    spriteEncoder enc0 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .view      (viewW),
        .Sprite    (Sprite)
    );

endmodule

// File: logic/pet_config.svh
/* Game constants for the pet core. Counters must fit in PET_STAT_W bits,
   so PET_STAT_MAX stays below 2**PET_STAT_W. PET_FRAME_DIV must be 1 or more. */
`ifndef PET_CONFIG_SVH
`define PET_CONFIG_SVH

// ----------------------------------------
// Keyboard scan codes
// ----------------------------------------
`define PET_KEY_FEED    8'h14   // Feed the pet
`define PET_KEY_PET     8'h1A   // Pet the pet
`define PET_KEY_START   8'h16   // Restart after death

// ----------------------------------------
// Well-being counters
// ----------------------------------------
`define PET_STAT_W      4       // Counter width in bits
`define PET_STAT_INIT   5       // Value after start
`define PET_STAT_MAX    10      // Upper cap
`define PET_HAPPY_MIN   5       // Lowest value still happy

// Behavior pacing
`define PET_FRAME_DIV   2       // Clock cycles per behavior step

`endif

// File: logic/spriteEncoder.sv
/* Stage 3. Registered sprite code, one clock after the view.
   High nibble picks the animation and the low nibble is frame + 1. */
module spriteEncoder (
    input  logic           Reset,
    input  logic           frame_clk,
    input  petPkg::petView view,
    output logic [7:0]     Sprite
);
    import petPkg::*;

    logic [3:0] frameCode;
    logic [7:0] code;

    assign frameCode = {1'b0, view.frame} + 4'd1;   // Frames show as 1..8

    // ----------------------------------------
    // Phase to sprite lookup
    // ----------------------------------------
    always_comb begin
        unique case (view.phase)
            phIdleHappy: code = {4'hA, frameCode};
            phIdleSad:   code = {4'hB, frameCode};
            phFeed:      code = {4'hC, frameCode};
            phPet:       code = {4'hD, frameCode};
            phUpset,
            phDead:      code = 8'h01;   // Sad face
            default:     code = 8'h00;   // Neutral face
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            Sprite <= 8'h00;
        end else begin
            Sprite <= code;
        end
    end

endmodule

// File: project.f
+incdir+logic
logic/petPkg.sv
logic/keyDecoder.sv
logic/petController.sv
logic/spriteEncoder.sv
logic/petTop.sv
verification/clockGen.sv
verification/petTb.sv

// File: run.sh
#!/bin/sh
# Build and run the pet testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module petTb \
    -f project.f \
    -o petSim

out=$(./obj_dir/petSim)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// File: verification/clockGen.sv
/* Clock and reset for the pet testbench. 8 ns clock; reset is active high
   and held across the first 2 rising edges, released 1 ns after the second. */
module clockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod = 4;   // 8 ns period

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        #1 rst = 1'b1;                  // Rising edge fires the async reset
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;                  // Release away from the clock edge
    end

endmodule

// File: verification/petTb.sv
/* Testbench for petTop. A cycle model of the pet rules runs beside the DUT and
   concurrent assertions compare Sprite and stats with it on every clock. */
`include "pet_config.svh"

module petTb;
    timeunit 1ns;
    timeprecision 100ps;

    import petPkg::*;

    localparam int ClkPeriod   = 8;
    localparam int ActionSteps = 16;                        // Press, gate, 8 frames, check
    localparam int StepBudget  = 17 * ActionSteps + 60;     // Key actions plus idle decay

    logic       Reset;       // Clock
    logic       frame_clk;   // Async active-high reset
    logic [7:0] key;
    logic [7:0] Sprite;
    petStats    stats;

    int    seed;
    int    spriteErrors = 0;
    int    statsErrors  = 0;
    string testName     = "reset";

    // Model state
    int         mDiv;
    logic       mStep;
    logic       mStepQ;      // A step happened at the last edge
    petCmd      mCmd;
    petCmd      mUsedCmd;    // Command seen by the last step in idle or dead
    petPhase    mPhase;
    logic [2:0] mFrame;
    petStats    mStats;
    logic [7:0] expSprite;
    petPhase    nPhase;
    logic [2:0] nFrame;
    petStats    nStats;

    clockGen clk0 (.clk(Reset), .rst(frame_clk));

    petTop dut0 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .key       (key),
        .Sprite    (Sprite),
        .stats     (stats)
    );

    // ----------------------------------------
    // Model helpers
    // ----------------------------------------
    function automatic petCmd decodeKey(input logic [7:0] code);
        if (code == `PET_KEY_FEED) return cmdFeed;
        if (code == `PET_KEY_PET) return cmdPet;
        if (code == `PET_KEY_START) return cmdStart;
        return cmdNone;
    endfunction

    function automatic statVal lowerStat(input statVal v);
        return (v == statVal'(0)) ? v : v - statVal'(1);
    endfunction

    function automatic statVal raiseStat(input statVal v);
        return (v >= statVal'(`PET_STAT_MAX)) ? v : v + statVal'(1);
    endfunction

    function automatic statVal minStat(input petStats s);
        statVal m;
        m = s.health;
        if (s.fullness < m) m = s.fullness;
        if (s.affection < m) m = s.affection;
        return m;
    endfunction

    function automatic logic [7:0] spriteFor(input petPhase ph, input logic [2:0] fr);
        case (ph)
            phIdleHappy:     return 8'hA1 + {5'b0, fr};
            phIdleSad:       return 8'hB1 + {5'b0, fr};
            phFeed:          return 8'hC1 + {5'b0, fr};
            phPet:           return 8'hD1 + {5'b0, fr};
            phUpset, phDead: return 8'h01;
            default:         return 8'h00;
        endcase
    endfunction

    // ----------------------------------------
    // Reference model of the step rules
    // ----------------------------------------
    assign mStep = (mDiv == `PET_FRAME_DIV - 1);

    always_comb begin
        nPhase = mPhase;
        nFrame = mFrame;
        nStats = mStats;
        case (mPhase)
            phStart: begin
                nPhase           = phCheck;
                nFrame           = 3'd0;
                nStats.health    = statVal'(`PET_STAT_INIT);
                nStats.fullness  = statVal'(`PET_STAT_INIT);
                nStats.affection = statVal'(`PET_STAT_INIT);
            end
            phCheck: begin
                nFrame = 3'd0;
                if (minStat(mStats) >= statVal'(`PET_HAPPY_MIN)) nPhase = phIdleHappy;
                else if (minStat(mStats) == statVal'(0)) nPhase = phDead;
                else nPhase = phIdleSad;
            end
            phIdleHappy, phIdleSad: begin
                if (mCmd == cmdFeed) begin
                    nPhase = phFeedGate;
                    nFrame = 3'd0;
                end else if (mCmd == cmdPet) begin
                    nPhase = phPetGate;
                    nFrame = 3'd0;
                end else if (mFrame == 3'd7) begin
                    nPhase           = phCheck;   // Day over so every counter drops
                    nFrame           = 3'd0;
                    nStats.health    = lowerStat(mStats.health);
                    nStats.fullness  = lowerStat(mStats.fullness);
                    nStats.affection = lowerStat(mStats.affection);
                end else begin
                    nFrame = mFrame + 3'd1;
                end
            end
            phFeedGate: begin
                nFrame = 3'd0;
                nPhase = (mStats.fullness < statVal'(`PET_STAT_MAX)) ? phFeed : phUpset;
            end
            phPetGate: begin
                nFrame = 3'd0;
                nPhase = (mStats.affection < statVal'(`PET_STAT_MAX)) ? phPet : phUpset;
            end
            phFeed, phPet: begin
                if (mFrame == 3'd7) begin
                    nPhase        = phCheck;
                    nFrame        = 3'd0;
                    nStats.health = raiseStat(mStats.health);
                    if (mPhase == phFeed) begin
                        nStats.fullness  = raiseStat(mStats.fullness);
                        nStats.affection = lowerStat(mStats.affection);
                    end else begin
                        nStats.affection = raiseStat(mStats.affection);
                        nStats.fullness  = lowerStat(mStats.fullness);
                    end
                end else begin
                    nFrame = mFrame + 3'd1;
                end
            end
            phUpset: begin
                nPhase        = phCheck;
                nFrame        = 3'd0;
                nStats.health = lowerStat(mStats.health);
            end
            phDead: begin
                if (mCmd == cmdStart) nPhase = phStart;   // Feed and pet do nothing
            end
            default: nPhase = phStart;
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            mDiv             <= 0;
            mStepQ           <= 1'b0;
            mCmd             <= cmdNone;
            mUsedCmd         <= cmdNone;
            mPhase           <= phStart;
            mFrame           <= 3'd0;
            mStats.health    <= statVal'(`PET_STAT_INIT);
            mStats.fullness  <= statVal'(`PET_STAT_INIT);
            mStats.affection <= statVal'(`PET_STAT_INIT);
            expSprite        <= 8'h00;
        end else begin
            mCmd      <= decodeKey(key);              // One clock of decode latency
            expSprite <= spriteFor(mPhase, mFrame);   // Sprite trails the view by a clock
            mStepQ    <= mStep;
            if (mStep) begin
                mDiv     <= 0;
                mPhase   <= nPhase;
                mFrame   <= nFrame;
                mStats   <= nStats;
                mUsedCmd <= (mPhase == phIdleHappy || mPhase == phIdleSad ||
                             mPhase == phDead) ? mCmd : cmdNone;
            end else begin
                mDiv <= mDiv + 1;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    spriteMatch: assert property (@(posedge Reset) disable iff (frame_clk) Sprite == expSprite)
        else begin
            spriteErrors++;
            $display("** Error [%s] Sprite: expected 0x%02h, actual 0x%02h",
                     testName, $sampled(expSprite), $sampled(Sprite));
        end

    statsMatch: assert property (@(posedge Reset) disable iff (frame_clk) stats == mStats)
        else begin
            statsErrors++;
            $display("** Error [%s] stats (h,f,a): expected 0x%03h, actual 0x%03h",
                     testName, $sampled(mStats), $sampled(stats));
        end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic nextCycle();
        @(posedge Reset);
        #1;                                  // Inputs move 1 ns after the edge
    endtask

    task automatic waitStep();
        do nextCycle(); while (!mStepQ);
    endtask

    task automatic waitSettled();            // Until a step lands in idle or dead
        do nextCycle();
        while (!(mStepQ && (mPhase == phIdleHappy || mPhase == phIdleSad || mPhase == phDead)));
    endtask

    task automatic waitDead();
        do nextCycle(); while (mPhase != phDead);
    endtask

    task automatic randomGap();
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) nextCycle();
    endtask

    task automatic pressKey(input logic [7:0] code);
        petCmd want;
        want = decodeKey(code);
        key  = code;
        do nextCycle(); while (!(mStepQ && mUsedCmd == want));
        key = 8'h00;                         // Released right after the step that took it
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : stimulus
        int n;
        seed = 39;
        key  = 8'h00;
        wait (frame_clk === 1'b1);
        wait (frame_clk === 1'b0);
        waitSettled();                       // Start, check, then happy idle

        testName = "feed";
        randomGap();
        pressKey(`PET_KEY_FEED);
        waitSettled();

        testName = "pet";
        randomGap();
        pressKey(`PET_KEY_PET);
        waitSettled();

        // Alternate feed and pet until health sits at the cap
        testName = "healthCap";
        for (n = 0; n < 4; n++) begin
            randomGap();
            pressKey((n % 2 == 0) ? `PET_KEY_FEED : `PET_KEY_PET);
            waitSettled();
        end

        testName = "idleDecay";
        waitDead();

        testName = "deadIgnore";
        pressKey(`PET_KEY_FEED);
        pressKey(`PET_KEY_PET);
        waitStep();

        testName = "restart";
        pressKey(`PET_KEY_START);
        waitSettled();

        testName = "petToDeath";
        n = 0;
        while (mPhase != phDead && n < 8) begin
            randomGap();
            pressKey(`PET_KEY_PET);
            waitSettled();
            n++;
        end
        waitStep();
        waitStep();

        $display("Error counts: sprite %0d, stats %0d, total %0d",
                 spriteErrors, statsErrors, spriteErrors + statsErrors);
        if (spriteErrors + statsErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(StepBudget * `PET_FRAME_DIV * ClkPeriod + 200);
        $display("Timeout: the run did not finish in time, stuck in test %s", testName);
        $display("Error counts: sprite %0d, stats %0d, total %0d",
                 spriteErrors, statsErrors, spriteErrors + statsErrors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
